/* filelist.f */
+incdir+include
source/fm_pkg.sv
source/fm_param_table.sv
source/fm_mmr.sv
source/fm_timers.sv
source/fm_slot_regs.sv
source/fm_regs_top.sv
testbench/fm_regs_tb.sv

/* testbench/fm_regs_tb.sv */
//********************
// Testbench for the FM register block
// cen is high on every second clock
// Each data write waits for busy to drop before the next one
// Stops at the first failed check
//********************
`timescale 1ns/10ps
`include "fm_defines.svh"

module fm_regs_tb;
    import fm_pkg::*;

    localparam int CLK_PERIOD     = 8;
    localparam int WATCHDOG_TICKS = 4000;   // About 50 writes of 34 ticks plus timer waits

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic cen = 1'b0;
    logic [7:0] din = 8'd0;
    logic write = 1'b0;
    logic a0 = 1'b0;
    logic [7:0] status, test_mode, lfo_freq;
    logic irq, ne, lfo_up, ct1, ct2, zero, keyon;
    logic [4:0] nfrq, cur_slot;
    logic [1:0] lfo_w;
    logic [6:0] lfo_amd, lfo_pmd;
    ch_params_t cur_ch_params;
    op_params_t cur_op_params;

    // Reference model
    ch_params_t [7:0]  ch_model;
    op_params_t [31:0] op_model;
    logic [31:0]       kon_model;
    logic [7:0] exp_test, exp_lfrq;
    logic [6:0] exp_amd, exp_pmd;
    logic [4:0] exp_nfrq;
    logic [1:0] exp_lfo_w;
    logic       exp_ne, exp_ct1, exp_ct2;

    fm_regs_top uut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;
    always @(posedge clk) cen <= !rst && !cen;

    task automatic stop_on_error(input string msg);
        $display("** FAIL **");
        $display("%s", msg);
        $fatal(1);
    endtask

    task automatic stop_on_mismatch(input string name, input logic [63:0] got,
                                    input logic [63:0] exp);
        stop_on_error($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else stop_on_mismatch(name, got, exp);
    endtask

    assert property (@(negedge clk) disable iff (rst) irq == (status[1] | status[0]))
        else stop_on_mismatch("irq", irq, status[1] | status[0]);
    assert property (@(negedge clk) disable iff (rst) zero == (cur_slot == 5'd0))
        else stop_on_mismatch("zero", zero, cur_slot == 5'd0);
    assert property (@(negedge clk) disable iff (rst) lfo_up |=> !lfo_up)
        else stop_on_error("lfo_up stayed high for more than one clock");
    assert property (@(posedge clk) disable iff (rst) cen |=> cur_slot == $past(cur_slot) + 5'd1)
        else stop_on_error("cur_slot did not advance on cen");

    // Address write then data write, returns at the negedge after the data write
    task automatic bus_write(input logic [7:0] addr, input logic [7:0] d);
        @(posedge clk);
        din   <= addr;
        a0    <= 1'b0;
        write <= 1'b1;
        @(posedge clk);
        din <= d;
        a0  <= 1'b1;
        @(posedge clk);
        write <= 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_busy_done();
        int ticks;
        ticks = 0;
        while (status[7]) begin
            if (cen) ticks++;       // Edge coming up is a cen tick
            @(negedge clk);
        end
        assert (ticks == `FM_BUSY_TICKS) else stop_on_mismatch("busy ticks", ticks, 32);
    endtask

    task automatic program_reg(input logic [7:0] addr, input logic [7:0] d);
        bus_write(addr, d);
        wait_busy_done();
    endtask

    task automatic global_write(input logic [7:0] addr, input logic [7:0] d);
        case (addr)
            `FM_REG_TEST:   exp_test = d;
            `FM_REG_NOISE:  {exp_ne, exp_nfrq} = {d[7], d[4:0]};
            `FM_REG_LFRQ:   exp_lfrq = d;
            `FM_REG_PMDAMD: begin
                if (d[7]) exp_pmd = d[6:0];
                else      exp_amd = d[6:0];
            end
            `FM_REG_CTW:    {exp_ct2, exp_ct1, exp_lfo_w} = {d[7:6], d[1:0]};
            default: ;
        endcase
        bus_write(addr, d);
        check_value("test_mode", test_mode, exp_test);
        check_value("ne", ne, exp_ne);
        check_value("nfrq", nfrq, exp_nfrq);
        check_value("lfo_freq", lfo_freq, exp_lfrq);
        check_value("lfo_amd", lfo_amd, exp_amd);
        check_value("lfo_pmd", lfo_pmd, exp_pmd);
        check_value("lfo_w", lfo_w, exp_lfo_w);
        check_value("ct1", ct1, exp_ct1);
        check_value("ct2", ct2, exp_ct2);
        check_value("lfo_up", lfo_up, addr == `FM_REG_LFRQ);
        wait_busy_done();
    endtask

    // Register map for 0x20 and up, slot = op * 8 + ch
    function automatic void update_model(input logic [7:0] addr, input logic [7:0] d);
        logic [2:0] ch;
        logic [4:0] slot;
        ch   = addr[2:0];
        slot = addr[4:0];
        case (addr[7:5])
            3'd1: begin
                case (addr[4:3])
                    2'd0: {ch_model[ch].rl, ch_model[ch].fb, ch_model[ch].con} = d;
                    2'd1: ch_model[ch].kc = d[6:0];
                    2'd2: ch_model[ch].kf = d[7:2];
                    default: {ch_model[ch].pms, ch_model[ch].ams} = {d[6:4], d[1:0]};
                endcase
            end
            3'd2: {op_model[slot].dt1, op_model[slot].mul} = d[6:0];
            3'd3: op_model[slot].tl = d[6:0];
            3'd4: {op_model[slot].ks, op_model[slot].ar} = {d[7:6], d[4:0]};
            3'd5: {op_model[slot].amsen, op_model[slot].d1r} = {d[7], d[4:0]};
            3'd6: {op_model[slot].dt2, op_model[slot].d2r} = {d[7:6], d[4:0]};
            default: {op_model[slot].d1l, op_model[slot].rr} = d;
        endcase
    endfunction

    task automatic keyon_write(input logic [7:0] d);
        for (int op = 0; op < 4; op++) begin
            kon_model[op * 8 + d[2:0]] = d[3 + op];
        end
        program_reg(`FM_REG_KON, d);
    endtask

    // One full round, sampled while the slot outputs are settled
    task automatic check_round();
        int n;
        n = 0;
        while (n < `FM_SLOTS) begin
            @(negedge clk);
            if (cen) begin
                check_value("cur_ch_params", cur_ch_params, ch_model[cur_slot[2:0]]);
                check_value("cur_op_params", cur_op_params, op_model[cur_slot]);
                check_value("keyon", keyon, kon_model[cur_slot]);
                n++;
            end
        end
    endtask

    task automatic wait_flag(input int idx, input int limit);
        int ticks;
        ticks = 0;
        while (!status[idx]) begin
            if (cen) ticks++;
            assert (ticks <= limit) else stop_on_error("timer flag did not rise in time");
            @(negedge clk);
        end
        check_value("irq", irq, 1);
    endtask

    task automatic check_cleared(input int idx);
        @(negedge clk);     // Clear pulse takes effect one clock later
        check_value("status flag", status[idx], 0);
        check_value("irq", irq, 0);
    endtask

    initial begin
        #(CLK_PERIOD * 2 * WATCHDOG_TICKS);
        stop_on_error("watchdog expired before the tests finished");
    end

    initial begin
        int va;
        int vb;
        logic [7:0] addr;
        logic [7:0] data;
        void'($urandom(14074));
        {exp_test, exp_lfrq, exp_amd, exp_pmd, exp_nfrq, exp_lfo_w} = '0;
        {exp_ne, exp_ct1, exp_ct2} = '0;
        ch_model  = '0;
        op_model  = '0;
        kon_model = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("status", status, 0);
        check_value("keyon", keyon, 0);

        global_write(`FM_REG_TEST, 8'($urandom));
        global_write(`FM_REG_NOISE, 8'($urandom));
        global_write(`FM_REG_LFRQ, 8'($urandom));
        global_write(`FM_REG_PMDAMD, 8'($urandom) | 8'h80);
        global_write(`FM_REG_PMDAMD, 8'($urandom) & 8'h7F);
        global_write(`FM_REG_CTW, 8'($urandom));
        global_write(8'h02, 8'($urandom));      // Unmapped
        global_write(8'h1F, 8'($urandom));

        repeat (24) begin
            addr = 8'h20 + 8'($urandom % 224);
            data = 8'($urandom);
            update_model(addr, data);
            program_reg(addr, data);
        end
        check_round();

        for (int ch = 0; ch < `FM_CHANNELS; ch++) begin
            keyon_write({1'b0, 4'($urandom), 3'(ch)});
        end
        check_round();

        // Timer A near the top of its range
        va = 1023 - int'($urandom % 8);
        program_reg(`FM_REG_CLKA1, 8'(va >> 2));
        program_reg(`FM_REG_CLKA2, 8'(va & 3));
        bus_write(`FM_REG_TIMER, 8'h05);
        fork
            wait_busy_done();
            wait_flag(0, 1024 - va + 2);
        join
        bus_write(`FM_REG_TIMER, 8'h11);       // Clear A, irq A off, keep running
        fork
            wait_busy_done();
            check_cleared(0);
        join
        keyon_write({1'b0, 4'h0, 3'($urandom % 8)});
        program_reg(`FM_REG_TIMER, 8'h81);     // CSM on overflow
        kon_model = '1;
        check_round();
        program_reg(`FM_REG_TIMER, 8'h00);

        vb = 255 - int'($urandom % 4);
        program_reg(`FM_REG_CLKB, 8'(vb));
        bus_write(`FM_REG_TIMER, 8'h0A);
        fork
            wait_busy_done();
            wait_flag(1, 16 * (256 - vb) + 2);
        join
        bus_write(`FM_REG_TIMER, 8'h22);
        fork
            wait_busy_done();
            check_cleared(1);
        join

        $display("** PASS **");
        $finish;
    end

endmodule

/* source/fm_regs_top.sv */
//********************
// FM register side top level
// status = {busy, 5'b0, flag_b, flag_a}
//********************
`timescale 1ns/10ps

module fm_regs_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic [7:0]         din,
    input  logic               write,
    input  logic               a0,
    output logic [7:0]         status,
    output logic               irq,
    output logic [7:0]         test_mode,
    output logic               ne,
    output logic [4:0]         nfrq,
    output logic [7:0]         lfo_freq,
    output logic [1:0]         lfo_w,
    output logic [6:0]         lfo_amd,
    output logic [6:0]         lfo_pmd,
    output logic               lfo_up,
    output logic               ct1,
    output logic               ct2,
    output logic [4:0]         cur_slot,
    output logic               zero,
    output fm_pkg::ch_params_t cur_ch_params,
    output fm_pkg::op_params_t cur_op_params,
    output logic               keyon
);
    import fm_pkg::*;

    logic       busy, flag_a, flag_b, overflow_a, csm;
    logic [9:0] value_a;
    logic [7:0] value_b, upd_data, kon_data;
    logic       load_a, load_b, enable_irq_a, enable_irq_b;
    logic       clr_flag_a, clr_flag_b, kon_pulse;
    upd_kind_t  upd;
    logic [2:0] upd_ch;
    logic [1:0] upd_op;

    assign status = {busy, 5'b0, flag_b, flag_a};

    fm_mmr u_mmr (
        .clk (clk), .rst (rst), .cen (cen),
        .din (din), .write (write), .a0 (a0),
        .busy (busy), .test_mode (test_mode), .ne (ne), .nfrq (nfrq),
        .lfo_freq (lfo_freq), .lfo_w (lfo_w), .lfo_amd (lfo_amd),
        .lfo_pmd (lfo_pmd), .lfo_up (lfo_up), .ct1 (ct1), .ct2 (ct2),
        .value_a (value_a), .value_b (value_b), .load_a (load_a), .load_b (load_b),
        .enable_irq_a (enable_irq_a), .enable_irq_b (enable_irq_b),
        .clr_flag_a (clr_flag_a), .clr_flag_b (clr_flag_b), .csm (csm),
        .upd (upd), .upd_data (upd_data), .upd_ch (upd_ch), .upd_op (upd_op),
        .kon_pulse (kon_pulse), .kon_data (kon_data)
    );

    fm_slot_regs u_slot_regs (
        .clk (clk), .rst (rst), .cen (cen),
        .upd (upd), .upd_data (upd_data), .upd_ch (upd_ch), .upd_op (upd_op),
        .kon_pulse (kon_pulse), .kon_data (kon_data),
        .csm (csm), .overflow_a (overflow_a),
        .cur_slot (cur_slot), .zero (zero),
        .cur_ch_params (cur_ch_params), .cur_op_params (cur_op_params),
        .keyon (keyon)
    );

    fm_timers u_timers (
        .clk (clk), .rst (rst), .cen (cen),
        .value_a (value_a), .value_b (value_b), .load_a (load_a), .load_b (load_b),
        .enable_irq_a (enable_irq_a), .enable_irq_b (enable_irq_b),
        .clr_flag_a (clr_flag_a), .clr_flag_b (clr_flag_b),
        .flag_a (flag_a), .flag_b (flag_b), .irq (irq), .overflow_a (overflow_a)
    );

endmodule

/* source/fm_slot_regs.sv */
//********************
// Slot sequencer and per-channel/per-operator parameter store
// Updates are read-modify-write through the table read port,
// taken on a clock without cen; outputs hold a copy meanwhile
// Key-on bit for operator n comes from kon_data bit 3+n
//********************
`timescale 1ns/10ps
`include "fm_defines.svh"

module fm_slot_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  fm_pkg::upd_kind_t  upd,
    input  logic [7:0]         upd_data,
    input  logic [2:0]         upd_ch,
    input  logic [1:0]         upd_op,
    input  logic               kon_pulse,
    input  logic [7:0]         kon_data,
    input  logic               csm,
    input  logic               overflow_a,
    output logic [4:0]         cur_slot,
    output logic               zero,
    output fm_pkg::ch_params_t cur_ch_params,
    output fm_pkg::op_params_t cur_op_params,
    output logic               keyon
);
    import fm_pkg::*;

    logic [4:0]         next_slot;
    upd_kind_t          kind_now, pend_kind, wr_kind;
    logic               rmw_rd, ch_we, op_we, shadow_on;
    ch_params_t         ch_rd, ch_copy;
    op_params_t         op_rd, op_copy;
    logic [`FM_SLOTS-1:0] kon_bits;

    function automatic ch_params_t merge_ch(input ch_params_t e, input upd_kind_t k,
                                            input logic [7:0] d);
        ch_params_t r;
        r = e;
        case (k)
            upd_ch_rlfbcon: {r.rl, r.fb, r.con} = d;
            upd_ch_kc:      r.kc = d[6:0];
            upd_ch_kf:      r.kf = d[7:2];
            upd_ch_pmsams:  {r.pms, r.ams} = {d[6:4], d[1:0]};
            default: ;
        endcase
        return r;
    endfunction

    function automatic op_params_t merge_op(input op_params_t e, input upd_kind_t k,
                                            input logic [7:0] d);
        op_params_t r;
        r = e;
        case (k)
            upd_op_dt1mul: {r.dt1, r.mul} = d[6:0];
            upd_op_tl:     r.tl = d[6:0];
            upd_op_ksar:   {r.ks, r.ar} = {d[7:6], d[4:0]};
            upd_op_amsd1r: {r.amsen, r.d1r} = {d[7], d[4:0]};
            upd_op_dt2d2r: {r.dt2, r.d2r} = {d[7:6], d[4:0]};
            upd_op_d1lrr:  {r.d1l, r.rr} = d;
            default: ;
        endcase
        return r;
    endfunction

    assign next_slot = cur_slot + 5'd1;
    assign zero      = (cur_slot == 5'd0);
    assign kind_now  = (upd != upd_none) ? upd : pend_kind;
    assign rmw_rd    = (kind_now != upd_none) && !cen;  // Port free of playback
    assign ch_we     = wr_kind inside {upd_ch_rlfbcon, upd_ch_kc, upd_ch_kf, upd_ch_pmsams};
    assign op_we     = (wr_kind != upd_none) && !ch_we;

    assign cur_ch_params = shadow_on ? ch_copy : ch_rd;
    assign cur_op_params = shadow_on ? op_copy : op_rd;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur_slot  <= 5'd0;
            pend_kind <= upd_none;
            wr_kind   <= upd_none;
            shadow_on <= 1'b0;
            kon_bits  <= '0;
            keyon     <= 1'b0;
        end else begin
            pend_kind <= (kind_now != upd_none && cen) ? kind_now : upd_none;
            wr_kind   <= rmw_rd ? kind_now : upd_none;
            if (cen) begin
                cur_slot  <= next_slot;
                keyon     <= kon_bits[next_slot];
                shadow_on <= 1'b0;
            end else if (rmw_rd) begin
                shadow_on <= 1'b1;
            end
            if (csm && overflow_a) begin
                kon_bits <= '1;     // CSM turns on every slot
            end else if (kon_pulse) begin
                for (int op = 0; op < 4; op++) begin
                    kon_bits[op * `FM_CHANNELS + kon_data[2:0]] <= kon_data[3 + op];
                end
            end
        end
    end

    // Playback value kept while the read port serves an update
    always_ff @(posedge clk) begin
        if (rmw_rd) begin
            ch_copy <= cur_ch_params;
            op_copy <= cur_op_params;
        end
    end

    fm_param_table #(.entry_t(ch_params_t), .DEPTH(`FM_CHANNELS)) u_ch_table (
        .clk   (clk),
        .rst   (rst),
        .we    (ch_we),
        .waddr (upd_ch),
        .wdata (merge_ch(ch_rd, wr_kind, upd_data)),
        .ren   (cen | rmw_rd),
        .raddr (rmw_rd ? upd_ch : next_slot[2:0]),
        .rdata (ch_rd)
    );

    fm_param_table #(.entry_t(op_params_t), .DEPTH(`FM_SLOTS)) u_op_table (
        .clk   (clk),
        .rst   (rst),
        .we    (op_we),
        .waddr ({upd_op, upd_ch}),
        .wdata (merge_op(op_rd, wr_kind, upd_data)),
        .ren   (cen | rmw_rd),
        .raddr (rmw_rd ? {upd_op, upd_ch} : next_slot),
        .rdata (op_rd)
    );

endmodule

/* source/fm_timers.sv */
//********************
// Timer A and timer B with flags and interrupt
// A timer sits at its reload value while its load bit is low
// Timer B advances once per 16 cen ticks
//********************
`timescale 1ns/10ps

module fm_timers (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic [9:0] value_a,
    input  logic [7:0] value_b,
    input  logic       load_a,
    input  logic       load_b,
    input  logic       enable_irq_a,
    input  logic       enable_irq_b,
    input  logic       clr_flag_a,
    input  logic       clr_flag_b,
    output logic       flag_a,
    output logic       flag_b,
    output logic       irq,
    output logic       overflow_a
);
    logic [9:0] cnt_a;
    logic [7:0] cnt_b;
    logic [3:0] pre_b;      // Timer B prescaler
    logic       tick_b, overflow_b;

    assign tick_b     = cen && (pre_b == 4'hF);
    assign overflow_a = cen && load_a && (cnt_a == 10'h3FF);
    assign overflow_b = tick_b && load_b && (cnt_b == 8'hFF);
    assign irq        = flag_a | flag_b;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_a  <= 10'd0;
            flag_a <= 1'b0;
        end else begin
            if (!load_a || overflow_a) cnt_a <= value_a;
            else if (cen)              cnt_a <= cnt_a + 10'd1;
            if (overflow_a && enable_irq_a) flag_a <= 1'b1;
            else if (clr_flag_a)            flag_a <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pre_b  <= 4'd0;
            cnt_b  <= 8'd0;
            flag_b <= 1'b0;
        end else begin
            if (cen) pre_b <= pre_b + 4'd1;
            if (!load_b || overflow_b) cnt_b <= value_b;
            else if (tick_b)           cnt_b <= cnt_b + 8'd1;
            if (overflow_b && enable_irq_b) flag_b <= 1'b1;
            else if (clr_flag_b)            flag_b <= 1'b0;
        end
    end

endmodule

/* source/fm_mmr.sv */
//********************
// Host bus decode and global registers
// Host must wait for busy to drop before the next data write
// Addresses 0x20 and up leave as one-clock update pulses
//********************
`timescale 1ns/10ps
`include "fm_defines.svh"

module fm_mmr (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic [7:0]        din,
    input  logic              write,
    input  logic              a0,
    output logic              busy,
    output logic [7:0]        test_mode,
    output logic              ne,
    output logic [4:0]        nfrq,
    output logic [7:0]        lfo_freq,
    output logic [1:0]        lfo_w,
    output logic [6:0]        lfo_amd,
    output logic [6:0]        lfo_pmd,
    output logic              lfo_up,
    output logic              ct1,
    output logic              ct2,
    output logic [9:0]        value_a,
    output logic [7:0]        value_b,
    output logic              load_a,
    output logic              load_b,
    output logic              enable_irq_a,
    output logic              enable_irq_b,
    output logic              clr_flag_a,
    output logic              clr_flag_b,
    output logic              csm,
    output fm_pkg::upd_kind_t upd,
    output logic [7:0]        upd_data,
    output logic [2:0]        upd_ch,
    output logic [1:0]        upd_op,
    output logic              kon_pulse,
    output logic [7:0]        kon_data
);
    import fm_pkg::*;

    logic [7:0] reg_sel;    // Address selected by the last a0=0 write
    logic [4:0] busy_cnt;
    logic       data_wr;

    assign data_wr = write & a0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reg_sel      <= 8'd0;
            test_mode    <= 8'd0;
            {ne, nfrq}   <= 6'd0;
            lfo_freq     <= 8'd0;
            lfo_w        <= 2'd0;
            lfo_amd      <= 7'd0;
            lfo_pmd      <= 7'd0;
            lfo_up       <= 1'b0;
            {ct2, ct1}   <= 2'd0;
            value_a      <= 10'd0;
            value_b      <= 8'd0;
            {enable_irq_b, enable_irq_a, load_b, load_a} <= 4'd0;
            {clr_flag_b, clr_flag_a} <= 2'd0;
            csm          <= 1'b0;
            kon_pulse    <= 1'b0;
            upd          <= upd_none;
        end else begin
            // Strobes last a single clock
            lfo_up     <= 1'b0;
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
            kon_pulse  <= 1'b0;
            upd        <= upd_none;
            if (write && !a0) begin
                reg_sel <= din;
            end
            if (data_wr && reg_sel < 8'h20) begin
                case (reg_sel)
                    `FM_REG_TEST:  test_mode <= din;
                    `FM_REG_KON:   kon_pulse <= 1'b1;
                    `FM_REG_NOISE: {ne, nfrq} <= {din[7], din[4:0]};
                    `FM_REG_CLKA1: value_a[9:2] <= din;
                    `FM_REG_CLKA2: value_a[1:0] <= din[1:0];
                    `FM_REG_CLKB:  value_b <= din;
                    `FM_REG_TIMER: begin
                        csm <= din[7];
                        {clr_flag_b, clr_flag_a, enable_irq_b, enable_irq_a,
                         load_b, load_a} <= din[5:0];
                    end
                    `FM_REG_LFRQ: begin
                        lfo_freq <= din;
                        lfo_up   <= 1'b1;   // Tells the LFO to restart its period
                    end
                    `FM_REG_PMDAMD: begin
                        if (din[7]) lfo_pmd <= din[6:0];
                        else        lfo_amd <= din[6:0];
                    end
                    `FM_REG_CTW: begin
                        {ct2, ct1} <= din[7:6];
                        lfo_w      <= din[1:0];
                    end
                    default: ;      // Unmapped, ignored
                endcase
            end else if (data_wr) begin
                if (reg_sel[7:5] == 3'd1) begin
                    // 0x20..0x3F, channel group in bits 4..3
                    case (reg_sel[4:3])
                        2'd0:    upd <= upd_ch_rlfbcon;
                        2'd1:    upd <= upd_ch_kc;
                        2'd2:    upd <= upd_ch_kf;
                        default: upd <= upd_ch_pmsams;
                    endcase
                end else begin
                    case (reg_sel[7:5])
                        3'd2:    upd <= upd_op_dt1mul;
                        3'd3:    upd <= upd_op_tl;
                        3'd4:    upd <= upd_op_ksar;
                        3'd5:    upd <= upd_op_amsd1r;
                        3'd6:    upd <= upd_op_dt2d2r;
                        default: upd <= upd_op_d1lrr;
                    endcase
                end
            end
        end
    end

    // Payload held until the next data write
    always_ff @(posedge clk) begin
        if (data_wr) begin
            upd_data <= din;
            upd_ch   <= reg_sel[2:0];
            upd_op   <= reg_sel[4:3];
            if (reg_sel == `FM_REG_KON) kon_data <= din;
        end
    end

    // Busy spans 32 cen ticks, restarted by every data write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= 5'd0;
        end else if (data_wr) begin
            busy     <= 1'b1;
            busy_cnt <= 5'd0;
        end else if (cen && busy) begin
            busy_cnt <= busy_cnt + 5'd1;
            if (busy_cnt == 5'(`FM_BUSY_TICKS - 1)) busy <= 1'b0;
        end
    end

endmodule

/* source/fm_param_table.sv */
//********************
// Small register table, one write and one registered read port
// rdata holds its value while ren is low
// Contents clear to zero on reset
//********************
`timescale 1ns/10ps

module fm_param_table #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  entry_t                   wdata,
    input  logic                     ren,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output entry_t                   rdata
);
    entry_t mem [DEPTH];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            if (we) mem[waddr] <= wdata;
            if (ren) rdata <= mem[raddr];   // Old data when read and write collide
        end
    end

endmodule

/* source/fm_pkg.sv */
//********************
// Channel and operator parameter entries, update kinds
// Field widths follow the chip register layout
//********************
package fm_pkg;

    typedef struct packed {
        logic [1:0] rl;     // Left/right enables
        logic [2:0] fb;
        logic [2:0] con;    // Algorithm
        logic [6:0] kc;
        logic [5:0] kf;
        logic [2:0] pms;
        logic [1:0] ams;
    } ch_params_t;

    typedef struct packed {
        logic [2:0] dt1;
        logic [3:0] mul;
        logic [6:0] tl;
        logic [1:0] ks;
        logic [4:0] ar;
        logic       amsen;
        logic [4:0] d1r;
        logic [1:0] dt2;
        logic [4:0] d2r;
        logic [3:0] d1l;
        logic [3:0] rr;
    } op_params_t;

    // Field group touched by one data write
    typedef enum logic [3:0] {
        upd_none,
        upd_ch_rlfbcon,
        upd_ch_kc,
        upd_ch_kf,
        upd_ch_pmsams,
        upd_op_dt1mul,
        upd_op_tl,
        upd_op_ksar,
        upd_op_amsd1r,
        upd_op_dt2d2r,
        upd_op_d1lrr
    } upd_kind_t;

endpackage

/* include/fm_defines.svh */
//********************
// Register map and sequencer sizes for the FM register block
// Addresses are 8-bit values as seen on the host bus
//********************
`ifndef FM_DEFINES_SVH
`define FM_DEFINES_SVH

// Global register addresses
`define FM_REG_TEST    8'h01
`define FM_REG_KON     8'h08
`define FM_REG_NOISE   8'h0F
`define FM_REG_CLKA1   8'h10
`define FM_REG_CLKA2   8'h11
`define FM_REG_CLKB    8'h12
`define FM_REG_TIMER   8'h14
`define FM_REG_LFRQ    8'h18
`define FM_REG_PMDAMD  8'h19
`define FM_REG_CTW     8'h1B

`define FM_SLOTS       32   // Slots per round, op * 8 + ch
`define FM_CHANNELS    8
`define FM_BUSY_TICKS  32   // cen ticks per data write

`endif
